// ==== mem_shim.f ====
+incdir+hdl
hdl/mem_shim_chan_pkg.sv
hdl/mem_shim_vtp_pkg.sv
hdl/mem_shim_rsp_order.sv
hdl/mem_shim_vtp.sv
hdl/mem_shim_pipe.sv
tests/tb_clock_gen.sv
tests/fiu_mem_model.sv
tests/mem_shim_tb.sv

// ==== Bender.yml ====
package:
  name: mem_shim

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_shim_chan_pkg.sv
      - hdl/mem_shim_vtp_pkg.sv
      - hdl/mem_shim_rsp_order.sv
      - hdl/mem_shim_vtp.sv
      - hdl/mem_shim_pipe.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/fiu_mem_model.sv
      - tests/mem_shim_tb.sv

// ==== tests/mem_shim_tb.sv ====
`timescale 1ns/1ps
`include "mem_shim_cfg.svh"

module mem_shim_tb
    import mem_shim_chan_pkg::*;
    import mem_shim_vtp_pkg::*;
();

    // Six tests of up to 200 requests, each taking up to 3 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int OFF_W          = `MEM_SHIM_PAGE_OFFSET_W;
    localparam int N_PAGES        = 2 ** `MEM_SHIM_VPAGE_W;

    logic       clk;
    logic       rst_n;
    logic       afu_rd_valid;
    vaddr_t     afu_rd_addr;
    mdata_t     afu_rd_mdata;
    logic       afu_wr_valid;
    vaddr_t     afu_wr_addr;
    line_data_t afu_wr_data;
    logic       afu_almost_full;
    logic       afu_rd_rsp_valid;
    mdata_t     afu_rd_rsp_mdata;
    line_data_t afu_rd_rsp_data;
    logic       fiu_rd_valid;
    paddr_t     fiu_rd_addr;
    rob_tag_t   fiu_rd_tag;
    logic       fiu_wr_valid;
    paddr_t     fiu_wr_addr;
    line_data_t fiu_wr_data;
    logic       fiu_almost_full;
    logic       fiu_rd_rsp_valid;
    rob_tag_t   fiu_rd_rsp_tag;
    line_data_t fiu_rd_rsp_data;
    logic       csr_wr_valid;
    vpage_t     csr_wr_vpage;
    ppage_t     csr_wr_ppage;
    logic       vtp_fault;
    logic       burst_enable;

    tb_clock_gen clk_gen_inst (.clk);
    mem_shim_pipe mem_shim_pipe_inst (.*);
    fiu_mem_model fiu_model_inst (.*);

    // ====================
    // Scoreboard state
    // ====================

    integer     seed;
    int         cycle = 0;
    int         errors = 0;
    int         errors_at_start = 0;
    int         tests_run = 0;
    int         rd_count = 0;
    int         rsp_count = 0;
    logic       af_seen;
    ppage_t     tb_pt_ppage [N_PAGES];
    logic       tb_pt_valid [N_PAGES];
    line_data_t shadow [paddr_t];
    mdata_t     exp_mdata [$];
    line_data_t exp_data [$];
    paddr_t     exp_rd_addr [$];
    rob_tag_t   exp_rd_tag [$];
    int         exp_rd_cycle [$];
    paddr_t     exp_wr_addr [$];
    line_data_t exp_wr_data [$];
    int         exp_wr_cycle [$];
    // Bus cycles in which vtp_fault must be high
    bit         exp_fault [int];

    // Same fill rule as the memory model uses for unwritten lines
    function automatic line_data_t ref_mem_data(paddr_t pa);
        return line_data_t'(pa) * 64'h9E37_79B9_7F4A_7C15;
    endfunction

    // Missing pages translate to physical page zero
    function automatic paddr_t ref_translate(vaddr_t va);
        vpage_t       vp;
        page_offset_t off;
        vp  = va[OFF_W +: `MEM_SHIM_VPAGE_W];
        off = va[OFF_W-1:0];
        return tb_pt_valid[vp] ? {tb_pt_ppage[vp], off} : {ppage_t'(0), off};
    endfunction

    function automatic line_data_t expected_line(paddr_t pa);
        return shadow.exists(pa) ? shadow[pa] : ref_mem_data(pa);
    endfunction

    task automatic check_value(logic [63:0] got, logic [63:0] exp, string what);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Sample almost-full at the edge, then clear the strobes 2 ns later
    task automatic step();
        @(posedge clk);
        af_seen = afu_almost_full;
        #2;
        afu_rd_valid = 1'b0;
        afu_wr_valid = 1'b0;
        csr_wr_valid = 1'b0;
    endtask

    task automatic load_page(vpage_t vp, ppage_t pp);
        csr_wr_valid    = 1'b1;
        csr_wr_vpage    = vp;
        csr_wr_ppage    = pp;
        tb_pt_ppage[vp] = pp;
        tb_pt_valid[vp] = 1'b1;
        step();
    endtask

    // Slots are handed out round the circular buffer from slot zero after reset
    task automatic send_read(vaddr_t va, mdata_t md);
        paddr_t pa;
        while (af_seen)
            step();
        pa           = ref_translate(va);
        afu_rd_valid = 1'b1;
        afu_rd_addr  = va;
        afu_rd_mdata = md;
        exp_mdata.push_back(md);
        exp_data.push_back(expected_line(pa));
        exp_rd_addr.push_back(pa);
        exp_rd_tag.push_back(rob_tag_t'(rd_count % `MEM_SHIM_ROB_DEPTH));
        exp_rd_cycle.push_back(cycle);
        if (!tb_pt_valid[va[OFF_W +: `MEM_SHIM_VPAGE_W]])
            exp_fault[cycle + 2] = 1'b1;
        rd_count++;
        step();
    endtask

    task automatic send_write(vaddr_t va, line_data_t data);
        paddr_t pa;
        while (af_seen)
            step();
        pa           = ref_translate(va);
        afu_wr_valid = 1'b1;
        afu_wr_addr  = va;
        afu_wr_data  = data;
        shadow[pa]   = data;
        exp_wr_addr.push_back(pa);
        exp_wr_data.push_back(data);
        exp_wr_cycle.push_back(cycle);
        if (!tb_pt_valid[va[OFF_W +: `MEM_SHIM_VPAGE_W]])
            exp_fault[cycle + 2] = 1'b1;
        step();
    endtask

    // Wait until every expected request and response has been seen
    task automatic drain();
        while (exp_mdata.size() > 0 || exp_wr_addr.size() > 0 || exp_rd_addr.size() > 0)
            step();
        repeat (2) step();
    endtask

    task automatic end_test(string name);
        drain();
        tests_run++;
        $display("test %-14s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ====================
    // Comparing process
    // ====================

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles before the tests were done", cycle);
            $display("TEST FAIL");
            $finish;
        end
        else if (rst_n)
        begin
            // Values seen at this edge were on the bus during cycle - 1
            check_value(vtp_fault, exp_fault.exists(cycle - 1), "vtp_fault");
            if (fiu_wr_valid && exp_wr_addr.size() == 0)
            begin
                $display("A write reached the FIU at %0t ns with none outstanding", $time);
                errors++;
            end
            else if (fiu_wr_valid)
            begin
                check_value(fiu_wr_addr, exp_wr_addr.pop_front(), "fiu_wr_addr");
                check_value(fiu_wr_data, exp_wr_data.pop_front(), "fiu_wr_data");
                check_value(cycle - 1 - exp_wr_cycle.pop_front(), 2, "write latency");
            end
            if (fiu_rd_valid && exp_rd_addr.size() == 0)
            begin
                $display("A read reached the FIU at %0t ns with none outstanding", $time);
                errors++;
            end
            else if (fiu_rd_valid)
            begin
                check_value(fiu_rd_addr, exp_rd_addr.pop_front(), "fiu_rd_addr");
                check_value(fiu_rd_tag, exp_rd_tag.pop_front(), "fiu_rd_tag");
                check_value(cycle - 1 - exp_rd_cycle.pop_front(), 2, "read latency");
            end
            // Every response strobe counts, expected or not
            if (afu_rd_rsp_valid)
                rsp_count++;
            if (afu_rd_rsp_valid && exp_mdata.size() == 0)
            begin
                $display("A read response came back at %0t ns with none expected", $time);
                errors++;
            end
            else if (afu_rd_rsp_valid)
            begin
                check_value(afu_rd_rsp_mdata, exp_mdata.pop_front(), "afu_rd_rsp_mdata");
                check_value(afu_rd_rsp_data, exp_data.pop_front(), "afu_rd_rsp_data");
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial
    begin
        vaddr_t addrs [30];
        int     rd_base;
        int     rsp_base;
        seed         = 92;
        rst_n        = 1'b0;
        afu_rd_valid = 1'b0;
        afu_rd_addr  = '0;
        afu_rd_mdata = '0;
        afu_wr_valid = 1'b0;
        afu_wr_addr  = '0;
        afu_wr_data  = '0;
        csr_wr_valid = 1'b0;
        csr_wr_vpage = '0;
        csr_wr_ppage = '0;
        burst_enable = 1'b0;
        af_seen      = 1'b0;
        foreach (tb_pt_valid[p])
            tb_pt_valid[p] = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Outputs are sampled at the edge, where they are stable
        @(posedge clk);
        check_value(afu_almost_full, 0, "afu_almost_full after reset");
        check_value(afu_rd_rsp_valid, 0, "afu_rd_rsp_valid after reset");
        check_value(fiu_rd_valid, 0, "fiu_rd_valid after reset");
        check_value(fiu_wr_valid, 0, "fiu_wr_valid after reset");
        check_value(vtp_fault, 0, "vtp_fault after reset");
        #2;
        end_test("reset");

        // Only the lower half of the pages is mapped, every page is touched
        for (int p = 0; p < N_PAGES / 2; p++)
            load_page(vpage_t'(p), ppage_t'($random(seed)));
        for (int i = 0; i < 24; i++)
        begin
            if (i % 2 == 1)
                send_read({vpage_t'(i), page_offset_t'($random(seed))},
                          mdata_t'($random(seed)));
            else
                send_write({vpage_t'(i), page_offset_t'($random(seed))},
                           {$random(seed), $random(seed)});
        end
        end_test("faults");

        for (int p = 0; p < N_PAGES; p++)
            load_page(vpage_t'(p), ppage_t'($random(seed)));
        for (int i = 0; i < 40; i++)
            send_write(vaddr_t'($random(seed)), {$random(seed), $random(seed)});
        end_test("translation");

        for (int i = 0; i < 200; i++)
            send_read(vaddr_t'($random(seed)), mdata_t'($random(seed)));
        end_test("in_order");

        foreach (addrs[i])
        begin
            addrs[i] = vaddr_t'($random(seed));
            send_write(addrs[i], {$random(seed), $random(seed)});
        end
        foreach (addrs[i])
            send_read(addrs[i], mdata_t'(i));
        end_test("read_after_write");

        // Back to back bursts against a full reorder buffer and FIU stalls
        burst_enable = 1'b1;
        rd_base      = rd_count;
        rsp_base     = rsp_count;
        for (int b = 0; b < 3; b++)
        begin
            for (int i = 0; i < 40; i++)
                send_read(vaddr_t'($random(seed)), mdata_t'($random(seed)));
            repeat (10) step();
        end
        drain();
        check_value(rsp_count - rsp_base, rd_count - rd_base, "response count");
        burst_enable = 1'b0;
        end_test("back_pressure");

        $display("tests %0d, reads %0d, responses %0d, errors %0d",
                 tests_run, rd_count, rsp_count, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== tests/fiu_mem_model.sv ====
`timescale 1ns/1ps

module fiu_mem_model
    import mem_shim_chan_pkg::*;
    import mem_shim_vtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       burst_enable,
    input  logic       fiu_rd_valid,
    input  paddr_t     fiu_rd_addr,
    input  rob_tag_t   fiu_rd_tag,
    input  logic       fiu_wr_valid,
    input  paddr_t     fiu_wr_addr,
    input  line_data_t fiu_wr_data,
    output logic       fiu_almost_full,
    output logic       fiu_rd_rsp_valid,
    output rob_tag_t   fiu_rd_rsp_tag,
    output line_data_t fiu_rd_rsp_data
);

    integer     seed = 92;
    int         mcycle;
    int         burst_left;
    line_data_t store [paddr_t];

    // Reads waiting for their random delay to run out
    rob_tag_t   pend_tag [$];
    paddr_t     pend_addr [$];
    int         pend_due [$];

    // Lines that were never written read back as a pattern of the address
    function automatic line_data_t fill_pattern(paddr_t pa);
        return line_data_t'(pa) * 64'h9E37_79B9_7F4A_7C15;
    endfunction

    initial
    begin
        mcycle           = 0;
        burst_left       = 0;
        fiu_almost_full  = 1'b0;
        fiu_rd_rsp_valid = 1'b0;
        fiu_rd_rsp_tag   = '0;
        fiu_rd_rsp_data  = '0;
    end

    // ====================
    // Request intake and responses
    // ====================

    always @(posedge clk)
    begin
        int         ready [$];
        int         pick;
        logic       rsp_valid;
        rob_tag_t   rsp_tag;
        line_data_t rsp_data;
        ready.delete();
        rsp_valid = 1'b0;
        rsp_tag   = '0;
        rsp_data  = '0;
        mcycle    = mcycle + 1;
        if (!rst_n)
        begin
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
            burst_left = 0;
        end
        else
        begin
            if (fiu_wr_valid)
                store[fiu_wr_addr] = fiu_wr_data;
            // Each read waits 1 to 8 cycles before it may be answered
            if (fiu_rd_valid)
            begin
                pend_tag.push_back(fiu_rd_tag);
                pend_addr.push_back(fiu_rd_addr);
                pend_due.push_back(mcycle + 1 + ($random(seed) & 7));
            end
            foreach (pend_due[i])
                if (pend_due[i] <= mcycle)
                    ready.push_back(i);
            // Any ready read may go first, which scrambles the return order
            if (ready.size() > 0)
            begin
                pick      = ready[($random(seed) & 32'h7fff_ffff) % ready.size()];
                rsp_valid = 1'b1;
                rsp_tag   = pend_tag[pick];
                rsp_data  = store.exists(pend_addr[pick]) ? store[pend_addr[pick]]
                                                          : fill_pattern(pend_addr[pick]);
                pend_tag.delete(pick);
                pend_addr.delete(pick);
                pend_due.delete(pick);
            end
            // Almost-full comes in bursts of 2 to 9 cycles
            if (burst_left > 0)
                burst_left = burst_left - 1;
            else if (burst_enable && (($random(seed) & 7) == 0))
                burst_left = 2 + ($random(seed) & 7);
        end
        #2;
        fiu_rd_rsp_valid = rsp_valid;
        fiu_rd_rsp_tag   = rsp_tag;
        fiu_rd_rsp_data  = rsp_data;
        fiu_almost_full  = (burst_left > 0);
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // Free running clock, low for the first half period
    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== hdl/mem_shim_pipe.sv ====
`timescale 1ns/1ps

module mem_shim_pipe
    import mem_shim_chan_pkg::*;
    import mem_shim_vtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // AFU edge
    input  logic       afu_rd_valid,
    input  vaddr_t     afu_rd_addr,
    input  mdata_t     afu_rd_mdata,
    input  logic       afu_wr_valid,
    input  vaddr_t     afu_wr_addr,
    input  line_data_t afu_wr_data,
    output logic       afu_almost_full,
    output logic       afu_rd_rsp_valid,
    output mdata_t     afu_rd_rsp_mdata,
    output line_data_t afu_rd_rsp_data,
    // FIU edge
    output logic       fiu_rd_valid,
    output paddr_t     fiu_rd_addr,
    output rob_tag_t   fiu_rd_tag,
    output logic       fiu_wr_valid,
    output paddr_t     fiu_wr_addr,
    output line_data_t fiu_wr_data,
    input  logic       fiu_almost_full,
    input  logic       fiu_rd_rsp_valid,
    input  rob_tag_t   fiu_rd_rsp_tag,
    input  line_data_t fiu_rd_rsp_data,
    // Page table loading and fault report
    input  logic       csr_wr_valid,
    input  vpage_t     csr_wr_vpage,
    input  ppage_t     csr_wr_ppage,
    output logic       vtp_fault
);

    // ====================
    // Ordering stage
    // ====================

    // Requests flow from the AFU through ordering and then translation
    // Responses skip translation and enter the ordering stage directly
    logic       ord_rd_valid;
    vaddr_t     ord_rd_addr;
    rob_tag_t   ord_rd_tag;
    logic       ord_wr_valid;
    vaddr_t     ord_wr_addr;
    line_data_t ord_wr_data;

    mem_shim_rsp_order rsp_order_inst (
        .clk, .rst_n,
        .afu_rd_valid, .afu_rd_addr, .afu_rd_mdata,
        .afu_wr_valid, .afu_wr_addr, .afu_wr_data, .afu_almost_full,
        .afu_rd_rsp_valid, .afu_rd_rsp_mdata, .afu_rd_rsp_data,
        .fiu_almost_full, .fiu_rd_rsp_valid, .fiu_rd_rsp_tag, .fiu_rd_rsp_data,
        .ord_rd_valid, .ord_rd_addr, .ord_rd_tag,
        .ord_wr_valid, .ord_wr_addr, .ord_wr_data
    );

    // ====================
    // Translation stage
    // ====================

    mem_shim_vtp vtp_inst (
        .clk, .rst_n,
        .csr_wr_valid, .csr_wr_vpage, .csr_wr_ppage,
        .ord_rd_valid, .ord_rd_addr, .ord_rd_tag,
        .ord_wr_valid, .ord_wr_addr, .ord_wr_data,
        .fiu_rd_valid, .fiu_rd_addr, .fiu_rd_tag,
        .fiu_wr_valid, .fiu_wr_addr, .fiu_wr_data,
        .vtp_fault
    );

endmodule

// ==== hdl/mem_shim_vtp.sv ====
`timescale 1ns/1ps
`include "mem_shim_cfg.svh"

module mem_shim_vtp
    import mem_shim_chan_pkg::*;
    import mem_shim_vtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Page table writes
    input  logic       csr_wr_valid,
    input  vpage_t     csr_wr_vpage,
    input  ppage_t     csr_wr_ppage,
    // Virtual requests from the ordering stage
    input  logic       ord_rd_valid,
    input  vaddr_t     ord_rd_addr,
    input  rob_tag_t   ord_rd_tag,
    input  logic       ord_wr_valid,
    input  vaddr_t     ord_wr_addr,
    input  line_data_t ord_wr_data,
    // Physical requests to the FIU
    output logic       fiu_rd_valid,
    output paddr_t     fiu_rd_addr,
    output rob_tag_t   fiu_rd_tag,
    output logic       fiu_wr_valid,
    output paddr_t     fiu_wr_addr,
    output line_data_t fiu_wr_data,
    output logic       vtp_fault
);

    localparam int N_PAGES = 2 ** `MEM_SHIM_VPAGE_W;

    // One entry per virtual page
    ppage_t             pt_ppage [N_PAGES];
    logic [N_PAGES-1:0] pt_valid;

    logic   rd_hit;
    logic   wr_hit;
    paddr_t rd_paddr;
    paddr_t wr_paddr;

    function automatic vpage_t vpage_of(vaddr_t va);
        return va[`MEM_SHIM_PAGE_OFFSET_W +: `MEM_SHIM_VPAGE_W];
    endfunction

    // Swap the page number and keep the offset
    // A miss maps to page zero so the request still reaches the FIU
    function automatic paddr_t phys_addr(vaddr_t va, ppage_t pp, logic hit);
        page_offset_t offset;
        offset = va[`MEM_SHIM_PAGE_OFFSET_W-1:0];
        return {(hit ? pp : ppage_t'(0)), offset};
    endfunction

    // ====================
    // Lookup
    // ====================

    always_comb
    begin
        rd_hit   = pt_valid[vpage_of(ord_rd_addr)];
        wr_hit   = pt_valid[vpage_of(ord_wr_addr)];
        rd_paddr = phys_addr(ord_rd_addr, pt_ppage[vpage_of(ord_rd_addr)], rd_hit);
        wr_paddr = phys_addr(ord_wr_addr, pt_ppage[vpage_of(ord_wr_addr)], wr_hit);
    end

    // ====================
    // Table and outputs
    // ====================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pt_valid     <= '0;
            fiu_rd_valid <= 1'b0;
            fiu_wr_valid <= 1'b0;
            vtp_fault    <= 1'b0;
        end
        else
        begin
            if (csr_wr_valid)
                pt_valid[csr_wr_vpage] <= 1'b1;
            fiu_rd_valid <= ord_rd_valid;
            fiu_wr_valid <= ord_wr_valid;
            // Both channels missing together still give a single pulse
            vtp_fault <= (ord_rd_valid && !rd_hit) || (ord_wr_valid && !wr_hit);
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_wr_valid)
            pt_ppage[csr_wr_vpage] <= csr_wr_ppage;
        fiu_rd_addr <= rd_paddr;
        fiu_rd_tag  <= ord_rd_tag;
        fiu_wr_addr <= wr_paddr;
        fiu_wr_data <= ord_wr_data;
    end

endmodule

// ==== hdl/mem_shim_rsp_order.sv ====
`timescale 1ns/1ps
`include "mem_shim_cfg.svh"

module mem_shim_rsp_order
    import mem_shim_chan_pkg::*;
    import mem_shim_vtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Requests from the AFU
    input  logic       afu_rd_valid,
    input  vaddr_t     afu_rd_addr,
    input  mdata_t     afu_rd_mdata,
    input  logic       afu_wr_valid,
    input  vaddr_t     afu_wr_addr,
    input  line_data_t afu_wr_data,
    output logic       afu_almost_full,
    // Read responses to the AFU in request order
    output logic       afu_rd_rsp_valid,
    output mdata_t     afu_rd_rsp_mdata,
    output line_data_t afu_rd_rsp_data,
    // FIU flow control and read responses in any order
    input  logic       fiu_almost_full,
    input  logic       fiu_rd_rsp_valid,
    input  rob_tag_t   fiu_rd_rsp_tag,
    input  line_data_t fiu_rd_rsp_data,
    // Tagged requests toward the translation stage
    output logic       ord_rd_valid,
    output vaddr_t     ord_rd_addr,
    output rob_tag_t   ord_rd_tag,
    output logic       ord_wr_valid,
    output vaddr_t     ord_wr_addr,
    output line_data_t ord_wr_data
);

    localparam int DEPTH = `MEM_SHIM_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Per slot storage, the metadata is written at allocation and the
    // data when the FIU answers
    mdata_t           mdata_mem [DEPTH];
    line_data_t       data_mem [DEPTH];
    logic [DEPTH-1:0] filled;

    // Head is the oldest outstanding read, tail the next free slot
    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CNT_W-1:0] used_cnt;
    logic [CNT_W-1:0] free_cnt;
    logic             release_head;

    // ====================
    // Flow control
    // ====================

    // The oldest read may leave as soon as its data is in
    assign release_head = filled[head];
    assign free_cnt     = CNT_W'(DEPTH) - used_cnt;

    // With the slack reserved, the AFU can never overrun the slots
    assign afu_almost_full = fiu_almost_full ||
                             (free_cnt <= CNT_W'(`MEM_SHIM_AF_SLACK));

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head             <= '0;
            tail             <= '0;
            used_cnt         <= '0;
            filled           <= '0;
            ord_rd_valid     <= 1'b0;
            ord_wr_valid     <= 1'b0;
            afu_rd_rsp_valid <= 1'b0;
        end
        else
        begin
            ord_rd_valid     <= afu_rd_valid;
            ord_wr_valid     <= afu_wr_valid;
            afu_rd_rsp_valid <= release_head;

            if (afu_rd_valid)
                tail <= tail + 1'b1;

            // A slot is never freed and filled in the same cycle, since the
            // head is only filled by its own single response
            if (release_head)
            begin
                filled[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (fiu_rd_rsp_valid)
                filled[fiu_rd_rsp_tag] <= 1'b1;

            case ({afu_rd_valid, release_head})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: used_cnt <= used_cnt;
            endcase
        end
    end

    // ====================
    // Payload path
    // ====================

    always_ff @(posedge clk)
    begin
        // Requests go out one cycle later, reads tagged with their slot
        ord_rd_addr <= afu_rd_addr;
        ord_rd_tag  <= tail;
        ord_wr_addr <= afu_wr_addr;
        ord_wr_data <= afu_wr_data;

        if (afu_rd_valid)
            mdata_mem[tail] <= afu_rd_mdata;
        if (fiu_rd_rsp_valid)
            data_mem[fiu_rd_rsp_tag] <= fiu_rd_rsp_data;

        // Only meaningful when afu_rd_rsp_valid is set
        afu_rd_rsp_mdata <= mdata_mem[head];
        afu_rd_rsp_data  <= data_mem[head];
    end

endmodule

// ==== hdl/mem_shim_vtp_pkg.sv ====
`include "mem_shim_cfg.svh"

// Address types for the virtual and the physical side of translation
package mem_shim_vtp_pkg;

    // ====================
    // Page level types
    // ====================

    // Page numbers before and after translation
    typedef logic [`MEM_SHIM_VPAGE_W-1:0] vpage_t;
    typedef logic [`MEM_SHIM_PPAGE_W-1:0] ppage_t;

    // Line offset inside a page, kept as is by translation
    typedef logic [`MEM_SHIM_PAGE_OFFSET_W-1:0] page_offset_t;

    // ====================
    // Line addresses
    // ====================

    // Virtual line address with the page number in the upper bits
    typedef logic [`MEM_SHIM_VPAGE_W+`MEM_SHIM_PAGE_OFFSET_W-1:0] vaddr_t;

    // Physical line address with the same layout
    typedef logic [`MEM_SHIM_PPAGE_W+`MEM_SHIM_PAGE_OFFSET_W-1:0] paddr_t;

endpackage

// ==== hdl/mem_shim_chan_pkg.sv ====
`include "mem_shim_cfg.svh"

// Types used on the request and response channels of the shim
package mem_shim_chan_pkg;

    // ====================
    // Payload types
    // ====================

    // One cache line as carried on the write and read response paths
    typedef logic [`MEM_SHIM_DATA_W-1:0] line_data_t;

    // Opaque AFU tag, stored per read and returned unchanged
    typedef logic [`MEM_SHIM_MDATA_W-1:0] mdata_t;

    // ====================
    // Ordering types
    // ====================

    // Index of a reorder slot
    // The same value travels to the FIU as the read tag and comes back
    // with the response, which is how data finds its slot again
    typedef logic [$clog2(`MEM_SHIM_ROB_DEPTH)-1:0] rob_tag_t;

endpackage

// ==== hdl/mem_shim_cfg.svh ====
`ifndef MEM_SHIM_CFG_SVH
`define MEM_SHIM_CFG_SVH

// Width of one cache line of data
`define MEM_SHIM_DATA_W 64

// Width of the AFU read metadata that is returned with each response
`define MEM_SHIM_MDATA_W 8

// Number of reorder slots, which bounds the reads in flight
// Must be a power of two so that the slot pointers wrap on their own
`define MEM_SHIM_ROB_DEPTH 16

// Virtual and physical page number widths
`define MEM_SHIM_VPAGE_W 4
`define MEM_SHIM_PPAGE_W 8

// Line offset within one page
`define MEM_SHIM_PAGE_OFFSET_W 12

// Requests a sender may still issue after almost-full rises
`define MEM_SHIM_AF_SLACK 4

`endif
